// File: Makefile
TOP := tb_servant

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "Simulation result: fail"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "Simulation result: no pass line in sim.log"; exit 1; fi
	@echo "Simulation result: pass"

lint:
	verilator --lint-only -Wall --timing --top-module servant -f list.f

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+.
servant_pkg.sv
servant_mux.sv
servant_arbiter.sv
servant_ram.sv
servant_io.sv
servant.sv
tb_clock.sv
tb_servant.sv

// File: servant.sv
`timescale 1ns/1ns
`include "servant_macros.svh"

module servant (
   input  logic                  i_wb_clk,
   input  logic                  i_rst,
   input  servant_pkg::wb_ireq_t i_ibus,
   output servant_pkg::wb_rsp_t  o_ibus,
   input  servant_pkg::wb_req_t  i_dbus,
   output servant_pkg::wb_rsp_t  o_dbus,
   output logic                  o_q,
   output logic                  o_timer_irq
);

   import servant_pkg::*;

   // Data bus after decode, RAM side.
   wb_req_t     dmem_req;
   wb_rsp_t     dmem_rsp;

   // Shared RAM port behind the arbiter.
   wb_req_t     ram_req;
   wb_rsp_t     ram_rsp;

   // GPIO and timer side.
   wb_req_t     io_req;
   logic        gpio_sel;
   logic        timer_sel;
   logic [31:0] io_rdt;

   servant_mux mux (
      .i_wb_clk    (i_wb_clk),
      .i_rst       (i_rst),
      .i_dbus      (i_dbus),
      .o_dbus      (o_dbus),
      .o_mem       (dmem_req),
      .i_mem       (dmem_rsp),
      .o_io        (io_req),
      .o_gpio_sel  (gpio_sel),
      .o_timer_sel (timer_sel),
      .i_io_rdt    (io_rdt)
   );

   servant_arbiter arbiter (
      .i_ibus (i_ibus),
      .o_ibus (o_ibus),
      .i_dbus (dmem_req),
      .o_dbus (dmem_rsp),
      .o_ram  (ram_req),
      .i_ram  (ram_rsp)
   );

   servant_ram #(
      .depth (`SERVANT_MEM_DEPTH)
   ) ram (
      .i_wb_clk (i_wb_clk),
      .i_rst    (i_rst),
      .i_req    (ram_req),
      .o_rsp    (ram_rsp)
   );

   servant_io #(
      .width (`SERVANT_TIMER_WIDTH)
   ) io (
      .i_wb_clk    (i_wb_clk),
      .i_rst       (i_rst),
      .i_req       (io_req),
      .i_gpio_sel  (gpio_sel),
      .i_timer_sel (timer_sel),
      .o_rdt       (io_rdt),
      .o_q         (o_q),
      .o_irq       (o_timer_irq)
   );

endmodule

// File: servant_arbiter.sv
`timescale 1ns/1ns

module servant_arbiter (
   input  servant_pkg::wb_ireq_t i_ibus,
   output servant_pkg::wb_rsp_t  o_ibus,
   input  servant_pkg::wb_req_t  i_dbus,
   output servant_pkg::wb_rsp_t  o_dbus,
   output servant_pkg::wb_req_t  o_ram,
   input  servant_pkg::wb_rsp_t  i_ram
);

   // The instruction bus always wins. A pending data access simply waits
   // until the instruction master drops cyc after its ack.
   always_comb begin
      o_ram.adr = i_ibus.cyc ? i_ibus.adr : i_dbus.adr;
      o_ram.dat = i_dbus.dat;
      o_ram.sel = i_dbus.sel;
      o_ram.we  = i_dbus.we && !i_ibus.cyc;
      o_ram.cyc = i_ibus.cyc || i_dbus.cyc;
   end

   // Read data goes to both sides, the ack only to the current owner.
   always_comb begin
      o_ibus.rdt = i_ram.rdt;
      o_ibus.ack = i_ram.ack && i_ibus.cyc;
      o_dbus.rdt = i_ram.rdt;
      o_dbus.ack = i_ram.ack && !i_ibus.cyc;
   end

endmodule

// File: servant_io.sv
`timescale 1ns/1ns
`include "servant_macros.svh"

module servant_io #(
   parameter int width = `SERVANT_TIMER_WIDTH
) (
   input  logic                 i_wb_clk,
   input  logic                 i_rst,
   input  servant_pkg::wb_req_t i_req,
   input  logic                 i_gpio_sel,
   input  logic                 i_timer_sel,
   output logic [31:0]          o_rdt,
   output logic                 o_q,
   output logic                 o_irq
);

   logic             q;
   logic [width-1:0] mtime;
   logic [width-1:0] mtimecmp;
   logic             wr;

   // The mux only presents cyc for one cycle per access.
   assign wr = i_req.cyc && i_req.we;

   // GPIO output bit. Byte selects are ignored, only data bit 0 matters.
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         q <= 1'b0;
      end else if (wr && i_gpio_sel) begin
         q <= i_req.dat[0];
      end
   end

   // Free-running counter, counting every clock from zero.
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         mtime <= '0;
      end else begin
         mtime <= mtime + 1'b1;
      end
   end

   // Compare starts at its maximum so that no interrupt fires after reset.
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         mtimecmp <= '1;
      end else if (wr && i_timer_sel) begin
         mtimecmp <= width'(i_req.dat);
      end
   end

   always_comb begin
      if (i_gpio_sel) begin
         o_rdt = {31'd0, q};
      end else if (i_timer_sel) begin
         o_rdt = 32'(mtime);
      end else begin
         o_rdt = 32'd0;
      end
   end

   assign o_q = q;

   // Level interrupt, held until software moves the compare value ahead.
   assign o_irq = (mtime >= mtimecmp);

endmodule

// File: servant_macros.svh
`ifndef SERVANT_MACROS_SVH
`define SERVANT_MACROS_SVH

// Size of the on-chip RAM in bytes. The RAM is organized as 32-bit words,
// so this must be a power of two and a multiple of four.
`define SERVANT_MEM_DEPTH 8192

// Width of the free-running machine timer and its compare register.
`define SERVANT_TIMER_WIDTH 32

// Data bus memory map, taken from address bits 31:30.
//   00  RAM, aliased over the whole region
//   01  GPIO output register
//   10  Machine timer
//   11  Unmapped, reads return zero
`endif

// File: servant_mux.sv
`timescale 1ns/1ns

module servant_mux (
   input  logic                 i_wb_clk,
   input  logic                 i_rst,
   input  servant_pkg::wb_req_t i_dbus,
   output servant_pkg::wb_rsp_t o_dbus,
   output servant_pkg::wb_req_t o_mem,
   input  servant_pkg::wb_rsp_t i_mem,
   output servant_pkg::wb_req_t o_io,
   output logic                 o_gpio_sel,
   output logic                 o_timer_sel,
   input  logic [31:0]          i_io_rdt
);

   import servant_pkg::*;

   region_t region;
   logic    io_cyc;
   logic    io_ack;

   assign region = region_t'(i_dbus.adr[31:30]);

   // Everything outside the RAM region is answered by this module itself.
   assign io_cyc = i_dbus.cyc && (region != REGION_MEM);

   assign o_gpio_sel  = (region == REGION_GPIO);
   assign o_timer_sel = (region == REGION_TIMER);

   // The memory side sees the request unchanged, except that cyc is only
   // passed on for the RAM region. Latency there is set by the arbiter.
   always_comb begin
      o_mem     = i_dbus;
      o_mem.cyc = i_dbus.cyc && (region == REGION_MEM);
   end

   // The I/O block only sees cyc in the first cycle of an access, so a write
   // takes effect once, on the same edge that raises the ack.
   always_comb begin
      o_io     = i_dbus;
      o_io.cyc = io_cyc && !io_ack && (region != REGION_NONE);
   end

   // One registered ack per access. The master still holds cyc in the ack
   // cycle, and the ack is cleared there instead of being raised again.
   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         io_ack <= 1'b0;
      end else begin
         io_ack <= io_cyc && !io_ack;
      end
   end

   always_comb begin
      o_dbus.ack = i_mem.ack || io_ack;
      case (region)
         REGION_MEM: begin
            o_dbus.rdt = i_mem.rdt;
         end
         REGION_GPIO, REGION_TIMER: begin
            o_dbus.rdt = i_io_rdt;
         end
         default: begin
            // Unmapped reads return zero.
            o_dbus.rdt = 32'd0;
         end
      endcase
   end

endmodule

// File: servant_pkg.sv
package servant_pkg;

   // Data bus request from the core. All fields stay stable while cyc is high.
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
      logic        cyc;
   } wb_req_t;

   // Instruction bus request. This bus only ever reads whole words.
   typedef struct packed {
      logic [31:0] adr;
      logic        cyc;
   } wb_ireq_t;

   // Response to either bus. Read data is only valid while ack is high.
   typedef struct packed {
      logic [31:0] rdt;
      logic        ack;
   } wb_rsp_t;

   // Address regions, decoded from data bus address bits 31:30.
   typedef enum logic [1:0] {
      REGION_MEM   = 2'b00,
      REGION_GPIO  = 2'b01,
      REGION_TIMER = 2'b10,
      REGION_NONE  = 2'b11
   } region_t;

endpackage

// File: servant_ram.sv
`timescale 1ns/1ns
`include "servant_macros.svh"

module servant_ram #(
   parameter int depth = `SERVANT_MEM_DEPTH
) (
   input  logic                 i_wb_clk,
   input  logic                 i_rst,
   input  servant_pkg::wb_req_t i_req,
   output servant_pkg::wb_rsp_t o_rsp
);

   localparam int aw = $clog2(depth);

   logic [31:0]   mem [0:depth/4-1];
   logic [aw-3:0] addr;
   logic [31:0]   rdt;
   logic          ack;

   // Upper address bits are ignored, so the RAM repeats across its region.
   assign addr = i_req.adr[aw-1:2];

   // Writes happen once, on the edge that raises the ack.
   always_ff @(posedge i_wb_clk) begin
      if (i_req.cyc && !ack && i_req.we) begin
         for (int i = 0; i < 4; i++) begin
            if (i_req.sel[i]) begin
               mem[addr][8*i +: 8] <= i_req.dat[8*i +: 8];
            end
         end
      end
      rdt <= mem[addr];
   end

   always_ff @(posedge i_wb_clk) begin
      if (i_rst) begin
         ack <= 1'b0;
      end else begin
         ack <= i_req.cyc && !ack;
      end
   end

   assign o_rsp.rdt = rdt;
   assign o_rsp.ack = ack;

endmodule

// File: tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
   parameter int period = 4
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
   end

   // Free-running clock, toggling every half period.
   always begin
      #(period / 2) o_clk = ~o_clk;
   end

endmodule

// File: tb_servant.sv
`timescale 1ns/1ns
`include "servant_macros.svh"

module tb_servant;

   import servant_pkg::*;

   localparam int mem_aw      = $clog2(`SERVANT_MEM_DEPTH);
   localparam int mem_words   = `SERVANT_MEM_DEPTH / 4;
   localparam int num_random  = 200;
   localparam int ack_limit   = 10;
   localparam int idle_cycles = 25;
   localparam logic [31:0] gpio_adr  = 32'h4000_0000;
   localparam logic [31:0] timer_adr = 32'h8000_0000;

   // One row of the directed stimulus table.
   typedef struct packed {
      logic        ibus;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        chk;
      logic [31:0] rdt_exp;
   } entry_t;

   logic        clk;
   logic        rst;
   wb_ireq_t    ibus_req;
   wb_rsp_t     ibus_rsp;
   wb_req_t     dbus_req;
   wb_rsp_t     dbus_rsp;
   logic        q;
   logic        timer_irq;

   logic [31:0] model_mem [0:mem_words-1];
   logic        model_q;
   entry_t      stim [$];
   logic        table_ready;
   integer      seed;

   tb_clock #(.period(4)) u_clock (.o_clk(clk));

   servant u_dut (
      .i_wb_clk    (clk),
      .i_rst       (rst),
      .i_ibus      (ibus_req),
      .o_ibus      (ibus_rsp),
      .i_dbus      (dbus_req),
      .o_dbus      (dbus_rsp),
      .o_q         (q),
      .o_timer_irq (timer_irq)
   );

   task automatic stop_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped.");
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
         stop_run();
      end
   endtask

   // Reference RAM. Only address bits below the RAM size select a word.
   function automatic logic [31:0] model_read(input logic [31:0] adr);
      return model_mem[adr[mem_aw-1:2]];
   endfunction

   function automatic void model_write(input logic [31:0] adr, input logic [31:0] dat,
                                       input logic [3:0] sel);
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            model_mem[adr[mem_aw-1:2]][8*i +: 8] = dat[8*i +: 8];
         end
      end
   endfunction

   function automatic logic [31:0] fill_pattern(input logic [31:0] adr);
      return (adr * 32'h9e37_79b9) ^ {adr[15:0], adr[31:16]};
   endfunction

   function automatic logic [31:0] window_adr(input logic [31:0] r);
      // Word 64 to 127 of the RAM, with random alias bits above the RAM size.
      return {2'b00, r[29:13], 4'b0000, 1'b1, r[5:0], 2'b00};
   endfunction

   task automatic dbus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel, output logic [31:0] rdt,
                              output int cycles);
      wb_req_t req;
      req.adr = adr;
      req.dat = dat;
      req.sel = sel;
      req.we  = we;
      req.cyc = 1'b1;
      @(posedge clk);
      dbus_req <= req;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > ack_limit) begin
            $display("No ack on the data bus for address %h.", adr);
            stop_run();
         end
         @(negedge clk);
      end while (!dbus_rsp.ack);
      rdt = dbus_rsp.rdt;
      @(posedge clk);
      dbus_req.cyc <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_equal(dbus_rsp.ack, 1'b0, "data ack after release");
      end
   endtask

   task automatic ibus_read(input logic [31:0] adr, output logic [31:0] rdt,
                            output int cycles);
      wb_ireq_t req;
      req.adr = adr;
      req.cyc = 1'b1;
      @(posedge clk);
      ibus_req <= req;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > ack_limit) begin
            $display("No ack on the instruction bus for address %h.", adr);
            stop_run();
         end
         @(negedge clk);
      end while (!ibus_rsp.ack);
      rdt = ibus_rsp.rdt;
      @(posedge clk);
      ibus_req.cyc <= 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_equal(ibus_rsp.ack, 1'b0, "instruction ack after release");
      end
   endtask

   function automatic void add_entry(input logic ibus, input logic we, input logic [31:0] adr,
                                     input logic [31:0] dat, input logic [3:0] sel,
                                     input logic chk, input logic [31:0] rdt_exp);
      entry_t e;
      e.ibus    = ibus;
      e.we      = we;
      e.adr     = adr;
      e.dat     = dat;
      e.sel     = sel;
      e.chk     = chk;
      e.rdt_exp = rdt_exp;
      stim.push_back(e);
   endfunction

   function automatic void build_table();
      add_entry(0, 1, 32'h0000_0010, 32'h1122_3344, 4'hf, 0, 32'h0);
      add_entry(0, 0, 32'h0000_0010, 32'h0,         4'hf, 1, 32'h1122_3344);
      add_entry(1, 0, 32'h0000_0010, 32'h0,         4'hf, 1, 32'h1122_3344);
      add_entry(0, 1, 32'h0000_0010, 32'haabb_ccdd, 4'h1, 0, 32'h0);
      add_entry(0, 1, 32'h0000_0010, 32'haabb_ccdd, 4'h4, 0, 32'h0);
      add_entry(0, 0, 32'h0000_0010, 32'h0,         4'hf, 1, 32'h11bb_33dd);
      add_entry(1, 0, 32'h0000_0010, 32'h0,         4'hf, 1, 32'h11bb_33dd);
      // 0x2014 and 0x3fffe014 both alias word 0x14 of an 8 KiB RAM.
      add_entry(0, 1, 32'h0000_2014, 32'hcafe_f00d, 4'hf, 0, 32'h0);
      add_entry(0, 0, 32'h0000_0014, 32'h0,         4'hf, 1, 32'hcafe_f00d);
      add_entry(1, 0, 32'h3fff_e014, 32'h0,         4'hf, 1, 32'hcafe_f00d);
      add_entry(0, 1, 32'h0000_0018, 32'h0102_0304, 4'hf, 0, 32'h0);
      add_entry(0, 1, 32'h0000_0018, 32'hf0f0_f0f0, 4'ha, 0, 32'h0);
      add_entry(0, 0, 32'h0000_2018, 32'h0,         4'hf, 1, 32'hf002_f004);
      add_entry(0, 1, 32'h0000_0018, 32'ha5a5_a5a5, 4'h6, 0, 32'h0);
      add_entry(1, 0, 32'h0000_0018, 32'h0,         4'hf, 1, 32'hf0a5_a504);
      add_entry(0, 1, gpio_adr,      32'h0000_0001, 4'hf, 0, 32'h0);
      add_entry(0, 0, gpio_adr,      32'h0,         4'hf, 1, 32'h0000_0001);
      add_entry(0, 1, 32'h4000_0004, 32'hffff_fffe, 4'hf, 0, 32'h0);
      add_entry(0, 0, gpio_adr,      32'h0,         4'hf, 1, 32'h0000_0000);
      add_entry(0, 1, gpio_adr,      32'h0000_0003, 4'hf, 0, 32'h0);
      add_entry(0, 0, gpio_adr,      32'h0,         4'hf, 1, 32'h0000_0001);
      add_entry(0, 1, 32'hc000_0000, 32'h1234_5678, 4'hf, 0, 32'h0);
      add_entry(0, 0, 32'hc000_0010, 32'h0,         4'hf, 1, 32'h0);
      add_entry(0, 0, 32'hffff_fffc, 32'h0,         4'hf, 1, 32'h0);
      add_entry(0, 0, timer_adr,     32'h0,         4'hf, 0, 32'h0);
   endfunction

   // Every directed access is uncontested, so each one acks after one cycle.
   task automatic apply_entry(input entry_t e);
      logic [31:0] rdt;
      int          cycles;
      if (e.ibus) begin
         ibus_read(e.adr, rdt, cycles);
      end else begin
         dbus_access(e.we, e.adr, e.dat, e.sel, rdt, cycles);
      end
      check_equal(cycles, 1, $sformatf("ack latency at %h", e.adr));
      if (e.chk) begin
         check_equal(rdt, e.rdt_exp, $sformatf("read data at %h", e.adr));
      end
      if (!e.ibus && e.we && e.adr[31:30] == REGION_MEM) begin
         model_write(e.adr, e.dat, e.sel);
      end
      if (!e.ibus && e.we && e.adr[31:30] == REGION_GPIO) begin
         model_q = e.dat[0];
      end
      check_equal(q, model_q, "GPIO output");
   endtask

   initial begin
      int limit;
      wait (table_ready == 1'b1);
      limit = (stim.size() + num_random) * 20;
      repeat (limit) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clock cycles.", limit);
      stop_run();
   end

   initial begin
      logic [31:0] rdt;
      logic [31:0] i_rdt;
      logic [31:0] t1;
      logic [31:0] t2;
      logic [31:0] r;
      logic [31:0] d_adr;
      logic [31:0] d_dat;
      logic [31:0] i_adr;
      logic [31:0] exp_d;
      logic [31:0] exp_i;
      logic [3:0]  d_sel;
      logic        d_we;
      logic        with_ibus;
      int          cycles;
      int          i_cycles;

      seed        = 32'h472e;
      model_q     = 1'b0;
      table_ready = 1'b0;
      rst         = 1'b1;
      ibus_req    = '0;
      dbus_req    = '0;
      build_table();
      table_ready = 1'b1;

      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_equal(q, 1'b0, "GPIO output after reset");
      check_equal(timer_irq, 1'b0, "timer interrupt after reset");
      check_equal(ibus_rsp.ack, 1'b0, "instruction ack after reset");
      check_equal(dbus_rsp.ack, 1'b0, "data ack after reset");

      foreach (stim[i]) begin
         apply_entry(stim[i]);
      end

      dbus_access(1'b0, timer_adr, 32'h0, 4'hf, t1, cycles);
      repeat (idle_cycles) @(posedge clk);
      dbus_access(1'b0, timer_adr, 32'h0, 4'hf, t2, cycles);
      check_equal((t2 - t1 >= idle_cycles) ? 32'd1 : 32'd0, 32'd1, "timer advance");

      // Compare set 50 ahead of the counter, so the interrupt rises later.
      dbus_access(1'b0, timer_adr, 32'h0, 4'hf, t1, cycles);
      dbus_access(1'b1, timer_adr, t1 + 32'd50, 4'hf, rdt, cycles);
      check_equal(timer_irq, 1'b0, "timer interrupt before compare");
      repeat (80) @(posedge clk);
      @(negedge clk);
      check_equal(timer_irq, 1'b1, "timer interrupt after compare");

      // Both masters start in the same cycle. The instruction read sees the old word.
      fork
         ibus_read(32'h0000_0014, i_rdt, i_cycles);
         dbus_access(1'b1, 32'h0000_0014, 32'hffff_0000, 4'h3, rdt, cycles);
      join
      check_equal(i_cycles, 1, "instruction latency under contention");
      check_equal(cycles, 3, "data latency under contention");
      check_equal(i_rdt, 32'hcafe_f00d, "instruction read under contention");
      model_write(32'h0000_0014, 32'hffff_0000, 4'h3);
      dbus_access(1'b0, 32'h0000_0014, 32'h0, 4'hf, rdt, cycles);
      check_equal(rdt, 32'hcafe_0000, "data read after contended write");

      for (int w = 0; w < 64; w++) begin
         d_adr = 32'h0000_0100 + 32'(w) * 4;
         d_dat = fill_pattern(d_adr);
         dbus_access(1'b1, d_adr, d_dat, 4'hf, rdt, cycles);
         model_write(d_adr, d_dat, 4'hf);
      end

      for (int n = 0; n < num_random; n++) begin
         r         = $random(seed);
         d_adr     = window_adr(r);
         d_we      = r[6];
         d_sel     = d_we ? r[10:7] : 4'hf;
         with_ibus = r[11];
         d_dat     = $random(seed);
         i_adr     = window_adr($random(seed));
         exp_d     = model_read(d_adr);
         exp_i     = model_read(i_adr);
         if (with_ibus) begin
            fork
               ibus_read(i_adr, i_rdt, i_cycles);
               dbus_access(d_we, d_adr, d_dat, d_sel, rdt, cycles);
            join
            check_equal(i_cycles, 1, "random instruction latency");
            check_equal(i_rdt, exp_i, $sformatf("random instruction read at %h", i_adr));
            check_equal(cycles, 3, "random contended data latency");
         end else begin
            dbus_access(d_we, d_adr, d_dat, d_sel, rdt, cycles);
            check_equal(cycles, 1, "random data latency");
         end
         if (d_we) begin
            model_write(d_adr, d_dat, d_sel);
         end else begin
            check_equal(rdt, exp_d, $sformatf("random data read at %h", d_adr));
         end
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
